/* Makefile */
# Verilator build and run of the branch front end testbench

LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal \
		--top-module branch_frontend_tb -f branch_frontend.f \
		--Mdir obj_dir -o sim
	./obj_dir/sim | tee $(LOG)
	@if grep -q "test failed" $(LOG); then echo "FAIL"; exit 1; fi
	@if ! grep -q "test passed" $(LOG); then echo "FAIL"; exit 1; fi
	@echo "PASS"

clean:
	rm -rf obj_dir $(LOG)

/* branch_frontend.f */
verilog/bp_pkg.sv
verilog/branch_predictor.sv
verilog/fetch_unit.sv
verilog/branch_resolver.sv
verilog/fetch_ctrl.sv
verilog/branch_stats.sv
verilog/branch_frontend.sv
tests/branch_frontend_chk.sv
tests/branch_frontend_tb.sv

/* tests/branch_frontend_chk.sv */
////////////////////////////////////////////////////////////////////////////
// Branch front end control checks
// Redirect bubble timing and stall behavior, bound into the top level
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module branch_frontend_chk (
  input logic        clk,
  input logic        rst,
  input logic        enable,
  input logic        mispredicted,  // Resolver output
  input logic        redirect,
  input logic        if_id_valid,
  input logic [15:0] fetch_pc
);

  int fails;  // Failed assertion count for the closing tally

  initial fails = 0;

  // An enabled mispredict opens the bubble at the next cycle
  redirect_after_miss: assert property (
    @(posedge clk) disable iff (rst) enable && mispredicted |=> redirect
  ) else begin
    $error("redirect did not follow an enabled mispredict");
    fails++;
  end

  // Bubble lasts one enabled cycle only
  redirect_one_cycle: assert property (
    @(posedge clk) disable iff (rst) enable && redirect |=> !redirect
  ) else begin
    $error("redirect stayed high for more than one cycle");
    fails++;
  end

  redirect_bubble: assert property (
    @(posedge clk) disable iff (rst) redirect |-> !if_id_valid
  ) else begin
    $error("IF/ID held a valid entry during redirect");
    fails++;
  end

  // Stall freezes the fetch address
  stall_holds_pc: assert property (
    @(posedge clk) disable iff (rst) !enable |=> $stable(fetch_pc)
  ) else begin
    $error("fetch_pc moved while enable was low");
    fails++;
  end

endmodule

bind branch_frontend branch_frontend_chk u_chk (
  .clk(clk), .rst(rst), .enable(enable),
  .mispredicted(mispredicted), .redirect(redirect),
  .if_id_valid(if_id.valid), .fetch_pc(fetch_pc)
);

/* tests/branch_frontend_tb.sv */
////////////////////////////////////////////////////////////////////////////
// Branch front end testbench
// Plays the decode stage for a small loop program and checks the DUT
// against a cycle model of the predictor, fetch PC and counters
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module branch_frontend_tb;

  logic                 clk, rst, enable;
  bp_pkg::resolve_t     resolve;
  logic [15:0]          fetch_pc;
  bp_pkg::fetch_entry_t if_id;
  logic                 redirect;
  logic [7:0]           branch_count, mispredict_count;

  branch_frontend uut (
    .clk(clk), .rst(rst), .enable(enable), .resolve(resolve),
    .fetch_pc(fetch_pc), .if_id(if_id), .redirect(redirect),
    .branch_count(branch_count), .mispredict_count(mispredict_count)
  );

  // Reference model state
  logic [15:0]          m_pc;
  bp_pkg::fetch_entry_t m_if;
  bp_pkg::bht_state_t   m_bht [0:7];
  logic [15:0]          m_btb [0:7];
  bp_pkg::fetch_state_t m_state;
  logic [7:0]           m_bcnt, m_mcnt;
  int errors, exits, iter, limit, hits, recoveries, cycles;
  logic [31:0] lfsr;
  logic checking;

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function logic rand_bit();
    logic b;
    b    = lfsr[0];
    lfsr = b ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);  // Galois step
    return b;
  endfunction

  function int new_limit();
    return 3 + int'({rand_bit(), rand_bit(), rand_bit()});  // 3 to 10 trips
  endfunction

  // Program with 0x06 never taken, 0x0C looping back to 0x04 and 0x0E jumping to 0x02
  function bp_pkg::resolve_t decode(input bp_pkg::fetch_entry_t e);
    bp_pkg::resolve_t r;
    r = '0;
    if (e.valid) begin
      case (e.pc)
        16'h0006: r = '{was_branch: 1'b1, actual_taken: 1'b0, actual_target: 16'h000E};
        16'h000C: r = '{was_branch: 1'b1, actual_taken: (iter < limit),
                        actual_target: 16'h0004};
        16'h000E: r = '{was_branch: 1'b1, actual_taken: 1'b1, actual_target: 16'h0002};
        default:  r = '0;
      endcase
    end
    return r;
  endfunction

  task check_value(input string name, input logic [15:0] exp, input logic [15:0] act);
    assert (exp === act) else begin
      errors++;
      $display("error %s expected %h actual %h", name, exp, act);
    end
  endtask

  // Model of one clock edge over the values of the ending cycle
  task model_edge();
    logic               taken, mis;
    logic [15:0]        cpc, tgt;
    bp_pkg::bht_state_t pred;
    taken = resolve.was_branch & resolve.actual_taken;
    mis   = m_if.valid && ((taken != m_if.prediction[1]) ||
            (taken && (m_if.predicted_target != resolve.actual_target)));
    cpc   = taken ? resolve.actual_target : m_if.pc + 16'd2;
    pred  = m_bht[m_pc[3:1]];  // Lookup before any table write
    tgt   = m_btb[m_pc[3:1]];
    if (!enable) return;
    if (m_if.valid && resolve.was_branch && m_bcnt != 8'hFF) m_bcnt = m_bcnt + 8'd1;
    if (mis && m_mcnt != 8'hFF) m_mcnt = m_mcnt + 8'd1;
    if (m_if.valid && taken) m_btb[m_if.pc[3:1]] = resolve.actual_target;
    if (mis) m_bht[m_if.pc[3:1]] = bp_pkg::next_state(m_if.prediction, taken);
    if (m_if.valid && m_if.pc == 16'h000C) begin  // Loop branch bookkeeping
      if (taken) begin
        iter++;
      end else begin
        iter = 0;
        limit = new_limit();
        exits++;
      end
    end
    if (m_state == bp_pkg::idle) begin
      m_state = bp_pkg::run;
    end else begin
      m_if = '{valid: !mis, pc: m_pc, prediction: pred, predicted_target: tgt};
      if (mis) m_pc = cpc;
      else if (pred[1] && tgt != 16'h0000) m_pc = tgt;
      else m_pc = m_pc + 16'd2;
      m_state = mis ? bp_pkg::redirect : bp_pkg::run;
    end
  endtask

  // Advance one cycle and drive a mispredicting resolve into a stalled one
  task cycle(input logic en_next);
    bp_pkg::resolve_t r;
    @(posedge clk);
    model_edge();
    r = decode(m_if);
    if (!en_next) begin
      r.was_branch   = 1'b1;
      r.actual_taken = ~m_if.prediction[1];  // Opposite of the prediction
      r.actual_target = 16'hBEEF;
    end
    enable  <= en_next;
    resolve <= r;
  endtask

  // Outputs are stable at the falling edge
  always @(negedge clk) begin
    if (checking) begin
      check_value("fetch_pc", m_pc, fetch_pc);
      check_value("if_id_valid", {15'd0, m_if.valid}, {15'd0, if_id.valid});
      if (m_if.valid) begin
        check_value("if_id_pc", m_if.pc, if_id.pc);
        check_value("if_id_prediction", {14'd0, m_if.prediction}, {14'd0, if_id.prediction});
        check_value("if_id_target", m_if.predicted_target, if_id.predicted_target);
      end
      check_value("redirect", {15'd0, m_state == bp_pkg::redirect}, {15'd0, redirect});
      check_value("branch_count", {8'd0, m_bcnt}, {8'd0, branch_count});
      check_value("mispredict_count", {8'd0, m_mcnt}, {8'd0, mispredict_count});
      // Loop branch followed to its target without a bubble
      if (if_id.valid && if_id.pc == 16'h000C && fetch_pc == 16'h0004 && !redirect) hits++;
      // Loop exit recovered onto the fall-through address
      if (redirect && fetch_pc == 16'h000E) recoveries++;
    end
  end

  initial begin
    rst = 1'b1;
    enable = 1'b0;
    resolve = '0;
    errors = 0;
    exits = 0;
    iter = 0;
    hits = 0;
    recoveries = 0;
    checking = 1'b0;
    lfsr = 32'd97431;
    limit = new_limit();
    m_pc = 16'h0000;  // RESET_PC
    m_if = '0;
    m_state = bp_pkg::idle;
    m_bcnt = '0;
    m_mcnt = '0;
    for (int i = 0; i < 8; i++) begin
      m_bht[i] = bp_pkg::strong_not_taken;
      m_btb[i] = 16'h0000;
    end
    repeat (2) @(posedge clk);
    rst <= 1'b0;
    enable <= 1'b1;
    checking = 1'b1;
    cycles = 0;
    while (exits < 1 && cycles < 500) begin  // First loop exit
      cycle(1'b1);
      cycles++;
    end
    if (exits < 1) begin
      errors++;
      $display("timeout waiting for the first loop exit");
    end else begin
      repeat (6) cycle(1'b0);  // Stall window
      cycle(1'b1);
      cycles = 0;
      while (exits < 4 && cycles < 2000) begin
        cycle(1'b1);
        cycles++;
      end
      if (exits < 4) begin
        errors++;
        $display("timeout waiting for four loop exits");
      end
      repeat (2) cycle(1'b1);
    end
    assert (hits > 0) else begin
      errors++;
      $display("loop branch was never predicted taken correctly");
    end
    assert (recoveries > 0) else begin
      errors++;
      $display("no loop exit recovered from a taken prediction");
    end
    errors += uut.u_chk.fails;  // Concurrent assertion failures
    $display("errors %0d branches %0d mispredicts %0d", errors, m_bcnt, m_mcnt);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

/* verilog/bp_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// Branch front end definitions
// Predictor counter and fetch FSM states, the IF/ID entry, the decode
// stage resolve bundle and the 2-bit saturating counter step
////////////////////////////////////////////////////////////////////////////
package bp_pkg;

  // 2-bit predictor counter, bit 1 set means predict taken
  typedef enum logic [1:0] {
    strong_not_taken = 2'b00,
    weak_not_taken   = 2'b01,
    weak_taken       = 2'b10,
    strong_taken     = 2'b11
  } bht_state_t;

  // Fetch control FSM
  typedef enum logic [1:0] {
    idle     = 2'b00,  // Out of reset, waiting for enable
    run      = 2'b01,  // Normal fetch
    redirect = 2'b10   // One-cycle bubble after a mispredict
  } fetch_state_t;

  // IF/ID pipeline register contents
  typedef struct packed {
    logic        valid;             // Entry holds a real fetch
    logic [15:0] pc;                // Halfword aligned fetch address
    bht_state_t  prediction;        // BHT state seen at fetch time
    logic [15:0] predicted_target;  // BTB target seen at fetch time
  } fetch_entry_t;

  // Outcome of the IF/ID instruction from decode
  typedef struct packed {
    logic        was_branch;
    logic        actual_taken;
    logic [15:0] actual_target;
  } resolve_t;

  // One step toward taken or not taken, saturating at both ends
  function automatic bht_state_t next_state(input bht_state_t state, input logic taken);
    bht_state_t nxt;
    case (state)
      strong_not_taken: nxt = taken ? weak_not_taken : strong_not_taken;
      weak_not_taken:   nxt = taken ? weak_taken     : strong_not_taken;
      weak_taken:       nxt = taken ? strong_taken   : weak_not_taken;
      default:          nxt = taken ? strong_taken   : weak_taken;  // Strong taken
    endcase
    return nxt;
  endfunction

endpackage

/* verilog/branch_frontend.sv */
////////////////////////////////////////////////////////////////////////////
// Instruction fetch front end
// Fetch PC, dynamic branch predictor, IF/ID register, resolver, fetch
// control and branch statistics of the 16-bit pipelined CPU
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module branch_frontend #(
  parameter int          IDX_BITS  = 3,       // 8 predictor entries
  parameter logic [15:0] RESET_PC  = 16'h0000,
  parameter int          STAT_BITS = 8
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 enable,
  input  bp_pkg::resolve_t     resolve,           // For the current IF/ID entry
  output logic [15:0]          fetch_pc,
  output bp_pkg::fetch_entry_t if_id,
  output logic                 redirect,
  output logic [STAT_BITS-1:0] branch_count,
  output logic [STAT_BITS-1:0] mispredict_count
);

  bp_pkg::bht_state_t prediction;
  logic [15:0]        predicted_target;
  logic               mispredicted;
  logic [15:0]        correct_pc;
  logic               bht_write;
  logic               btb_write;
  logic               advance;
  logic               flush;

  fetch_unit #(.RESET_PC(RESET_PC)) u_fetch (
    .clk(clk), .rst(rst),
    .advance(advance), .flush(flush),
    .redirect_now(mispredicted), .correct_pc(correct_pc),
    .prediction(prediction), .predicted_target(predicted_target),
    .fetch_pc(fetch_pc), .if_id(if_id)
  );

  branch_predictor #(.IDX_BITS(IDX_BITS)) u_predictor (
    .clk(clk), .rst(rst),
    .fetch_pc(fetch_pc), .if_id(if_id), .resolve(resolve),
    .bht_write(bht_write), .btb_write(btb_write), .enable(enable),
    .prediction(prediction), .predicted_target(predicted_target)
  );

  branch_resolver u_resolver (
    .if_id(if_id), .resolve(resolve),
    .mispredicted(mispredicted), .correct_pc(correct_pc),
    .bht_write(bht_write), .btb_write(btb_write)
  );

  fetch_ctrl u_ctrl (
    .clk(clk), .rst(rst),
    .enable(enable), .mispredicted(mispredicted),
    .advance(advance), .flush(flush), .redirect(redirect)
  );

  // Every valid branch counts, taken or not
  branch_stats #(.STAT_BITS(STAT_BITS)) u_stats (
    .clk(clk), .rst(rst), .enable(enable),
    .counted(if_id.valid & resolve.was_branch), .missed(mispredicted),
    .branch_count(branch_count), .mispredict_count(mispredict_count)
  );

endmodule

/* verilog/branch_predictor.sv */
////////////////////////////////////////////////////////////////////////////
// Dynamic branch predictor
// BHT of 2-bit counters and BTB of 16-bit targets, both read
// combinationally on the fetch PC and updated from the resolved branch
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module branch_predictor #(
  parameter int IDX_BITS = 3  // log2 of the table depth
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic [15:0]          fetch_pc,          // Lookup address
  input  bp_pkg::fetch_entry_t if_id,             // Entry being resolved
  input  bp_pkg::resolve_t     resolve,           // Decode stage outcome
  input  logic                 bht_write,         // Mispredicted, qualified by valid
  input  logic                 btb_write,         // Valid taken branch
  input  logic                 enable,            // Low freezes both tables
  output bp_pkg::bht_state_t   prediction,
  output logic [15:0]          predicted_target
);

  localparam int ENTRIES = 1 << IDX_BITS;

  bp_pkg::bht_state_t bht [0:ENTRIES-1];  // Branch history table
  logic [15:0]        btb [0:ENTRIES-1];  // Branch target buffer

  logic [IDX_BITS-1:0] rd_idx;      // Index of the fetch PC
  logic [IDX_BITS-1:0] wr_idx;      // Index of the IF/ID PC
  logic                step_taken;  // Direction to step the counter
  bp_pkg::bht_state_t  bht_new;

  // Halfword PCs, so bit 0 carries no information
  assign rd_idx = fetch_pc[IDX_BITS:1];
  assign wr_idx = if_id.pc[IDX_BITS:1];

  // A non-branch never counts as taken
  assign step_taken = resolve.was_branch & resolve.actual_taken;

  // New counter is stepped from the state carried down the pipe, not re-read
  assign bht_new = bp_pkg::next_state(if_id.prediction, step_taken);

  ////////////////////////////////////////////////////////////////////////////
  // Branch target buffer
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      btb <= '{default: 16'h0000};
    end else if (enable && btb_write) begin
      btb[wr_idx] <= resolve.actual_target;  // Learn where taken branches go
    end
  end

  assign predicted_target = btb[rd_idx];

  ////////////////////////////////////////////////////////////////////////////
  // Branch history table
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      bht <= '{default: bp_pkg::strong_not_taken};
    end else if (enable && bht_write) begin
      bht[wr_idx] <= bht_new;  // Only touched on a mispredict
    end
  end

  // Same-cycle read for the next-PC mux
  assign prediction = bht[rd_idx];

endmodule

/* verilog/branch_resolver.sv */
////////////////////////////////////////////////////////////////////////////
// Branch resolver
// Checks the decode stage outcome against the IF/ID prediction, gives the
// recovery PC and the predictor table write strobes
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module branch_resolver (
  input  bp_pkg::fetch_entry_t if_id,
  input  bp_pkg::resolve_t     resolve,
  output logic                 mispredicted,
  output logic [15:0]          correct_pc,
  output logic                 bht_write,
  output logic                 btb_write
);

  logic taken;       // Really taken, non-branches never are
  logic pred_taken;  // Direction chosen at fetch
  logic dir_miss;
  logic tgt_miss;

  assign taken      = resolve.was_branch & resolve.actual_taken;
  assign pred_taken = if_id.prediction[1];

  // Also catches a non-branch that was predicted taken
  assign dir_miss = taken ^ pred_taken;

  // Right direction but stale or missing BTB target
  assign tgt_miss = taken && (if_id.predicted_target != resolve.actual_target);

  assign mispredicted = if_id.valid && (dir_miss || tgt_miss);

  assign correct_pc = taken ? resolve.actual_target : (if_id.pc + 16'd2);

  // Table strobes, the predictor adds the enable qualifier
  assign btb_write = if_id.valid & taken;
  assign bht_write = mispredicted;

endmodule

/* verilog/branch_stats.sv */
////////////////////////////////////////////////////////////////////////////
// Branch statistics
// Saturating counts of resolved branches and mispredictions
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module branch_stats #(
  parameter int STAT_BITS = 8
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 enable,     // Low freezes both counts
  input  logic                 counted,    // Valid resolved branch
  input  logic                 missed,     // Mispredict this cycle
  output logic [STAT_BITS-1:0] branch_count,
  output logic [STAT_BITS-1:0] mispredict_count
);

  logic [STAT_BITS-1:0] branch_q;
  logic [STAT_BITS-1:0] miss_q;

  // Both counters stick at all ones
  always_ff @(posedge clk) begin
    if (rst) begin
      branch_q <= '0;
      miss_q   <= '0;
    end else if (enable) begin
      if (counted && (branch_q != '1)) branch_q <= branch_q + 1'b1;
      if (missed && (miss_q != '1))    miss_q   <= miss_q + 1'b1;
    end
  end

  assign branch_count     = branch_q;
  assign mispredict_count = miss_q;

endmodule

/* verilog/fetch_ctrl.sv */
////////////////////////////////////////////////////////////////////////////
// Fetch control FSM
// Sequences reset, run, stall and the one-cycle bubble after a mispredict
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module fetch_ctrl (
  input  logic clk,
  input  logic rst,
  input  logic enable,        // Low stalls the whole front end
  input  logic mispredicted,  // From the resolver, this cycle
  output logic advance,       // PC and IF/ID may load
  output logic flush,         // IF/ID loads a bubble at this edge
  output logic redirect       // Bubble cycle after the mispredict
);

  bp_pkg::fetch_state_t state;
  bp_pkg::fetch_state_t state_next;

  always_comb begin
    state_next = state;
    case (state)
      bp_pkg::idle: begin
        if (enable) state_next = bp_pkg::run;  // First enabled cycle
      end
      bp_pkg::run, bp_pkg::redirect: begin
        if (enable) begin
          state_next = mispredicted ? bp_pkg::redirect : bp_pkg::run;
        end
      end
      default: state_next = bp_pkg::idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= bp_pkg::idle;
    end else begin
      state <= state_next;  // Holds while enable is low
    end
  end

  assign advance = enable && (state != bp_pkg::idle);

  // Wrong-path fetch is killed at the same edge the PC is corrected
  assign flush = advance & mispredicted;

  // Registered mispredict, high for the bubble cycle
  assign redirect = (state == bp_pkg::redirect);

endmodule

/* verilog/fetch_unit.sv */
////////////////////////////////////////////////////////////////////////////
// Fetch unit
// Fetch PC register with next-PC selection and the IF/ID register,
// which captures each fetch with its prediction
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module fetch_unit #(
  parameter logic [15:0] RESET_PC = 16'h0000
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 advance,           // PC and IF/ID may load
  input  logic                 flush,             // IF/ID takes a bubble
  input  logic                 redirect_now,      // Mispredict, take correct_pc
  input  logic [15:0]          correct_pc,
  input  bp_pkg::bht_state_t   prediction,        // Lookup for fetch_pc
  input  logic [15:0]          predicted_target,
  output logic [15:0]          fetch_pc,
  output bp_pkg::fetch_entry_t if_id
);

  logic [15:0]          pc_q;
  logic [15:0]          pc_seq;     // Fall-through address
  logic                 pred_jump;  // Follow the BTB this cycle
  logic [15:0]          pc_next;
  bp_pkg::fetch_entry_t entry_d;
  bp_pkg::fetch_entry_t if_id_q;

  assign pc_seq = pc_q + 16'd2;

  // Zero target means the BTB entry was never written
  assign pred_jump = prediction[1] && (predicted_target != 16'h0000);

  always_comb begin
    if (redirect_now) begin
      pc_next = correct_pc;        // Recovery wins over any prediction
    end else if (pred_jump) begin
      pc_next = predicted_target;
    end else begin
      pc_next = pc_seq;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pc_q <= RESET_PC;
    end else if (advance) begin
      pc_q <= pc_next;
    end
  end

  // Entry for the instruction fetched this cycle
  always_comb begin
    entry_d.valid            = ~flush;  // Wrong-path fetch is dropped
    entry_d.pc               = pc_q;
    entry_d.prediction       = prediction;
    entry_d.predicted_target = predicted_target;
  end

  // Only the valid bit needs a known value out of reset
  always_ff @(posedge clk) begin
    if (rst) begin
      if_id_q.valid <= 1'b0;
    end else if (advance) begin
      if_id_q <= entry_d;
    end
  end

  assign fetch_pc = pc_q;
  assign if_id    = if_id_q;

endmodule
